// ==== common/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	localparam int WORD_BITS = 32;
	localparam int REG_ADDR_BITS = 5;

	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;

	typedef enum logic [5:0] {
		TY_BASE = 6'b100000,
		MOVI    = 6'b100010,
		ADDI    = 6'b101000,
		XORI    = 6'b101011,
		ORI     = 6'b101100,
		LWI     = 6'b000010,
		SWI     = 6'b001010,
		TY_LS   = 6'b011100
	} opcode_t;

	typedef enum logic [4:0] {
		ADD   = 5'b00000,
		SUB   = 5'b00001,
		AND   = 5'b00010,
		XOR   = 5'b00011,
		OR    = 5'b00100,
		SLLI  = 5'b01000,
		SRLI  = 5'b01001,
		ROTRI = 5'b01011
	} base_subop_t;

	typedef enum logic [7:0] {
		LW = 8'b00000010,
		SW = 8'b00001010
	} ls_subop_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SRL,
		ALU_SLL,
		ALU_ROTR
	} alu_op_t;

	// second alu operand
	typedef enum logic [1:0] {
		OPND_REG,
		OPND_IMM,
		OPND_IMM_OFS,
		OPND_REG_SV
	} operand_sel_t;

	typedef enum logic [1:0] {
		EXT_IMM5_ZERO,
		EXT_IMM15_SIGN,
		EXT_IMM15_ZERO,
		EXT_IMM20_SIGN
	} extend_sel_t;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_IMM,
		WB_MEM
	} wb_sel_t;

	typedef enum logic [2:0] {
		FETCH      = 3'd0,
		REG_FETCH  = 3'd1,
		EXECUTE    = 3'd2,
		MEMORY     = 3'd3,
		WRITE_BACK = 3'd4
	} cpu_state_t;

	// instruction fields
	function automatic opcode_t field_opcode(word_t w);
		return opcode_t'(w[30:25]);
	endfunction

	function automatic base_subop_t field_base_subop(word_t w);
		return base_subop_t'(w[4:0]);
	endfunction

	function automatic ls_subop_t field_ls_subop(word_t w);
		return ls_subop_t'(w[7:0]);
	endfunction

	function automatic reg_addr_t field_rt(word_t w);
		return w[24:20];
	endfunction

	function automatic reg_addr_t field_ra(word_t w);
		return w[19:15];
	endfunction

	function automatic reg_addr_t field_rb(word_t w);
		return w[14:10];
	endfunction

	function automatic logic [1:0] field_sv(word_t w);
		return w[9:8];
	endfunction

	function automatic logic [4:0] field_imm5(word_t w);
		return w[14:10];
	endfunction

	function automatic logic [14:0] field_imm15(word_t w);
		return w[14:0];
	endfunction

	function automatic logic [19:0] field_imm20(word_t w);
		return w[19:0];
	endfunction

endpackage

`default_nettype wire

// ==== dv/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
	import isa_pkg::*;

	localparam int MEM_ADDR_BITS = 8;
	localparam int NUM_KINDS = 19;
	localparam logic [5:0] UNKNOWN_OPCODE = 6'b111111;

	logic                     clock;
	logic                     reset;
	logic                     prog_write;
	logic [MEM_ADDR_BITS-1:0] prog_addr;
	word_t                    prog_data;
	logic                     retire;
	reg_addr_t                retire_reg;
	word_t                    retire_data;
	logic                     store;
	word_t                    store_addr;
	word_t                    store_data;

	integer    seed;
	int        prog_len;
	bit        running;
	bit        core_active;
	int        edge_count;
	int        mismatch_errors;
	int        other_errors;
	int        retire_seen;
	int        store_seen;
	int        exp_retire_total;
	int        exp_store_total;

	word_t     prog[$];
	bit        exp_retire[$];
	reg_addr_t exp_reg[$];
	word_t     exp_data[$];
	bit        exp_store[$];
	word_t     exp_addr[$];
	word_t     exp_sdata[$];

	// reference state
	word_t     model_regs [0:31];
	word_t     model_mem [0:(1 << MEM_ADDR_BITS)-1];

	cpu_top #(
		.MEM_ADDR_BITS (MEM_ADDR_BITS)
	) cpu_top_i (
		.clock       (clock),
		.reset       (reset),
		.prog_write  (prog_write),
		.prog_addr   (prog_addr),
		.prog_data   (prog_data),
		.retire      (retire),
		.retire_reg  (retire_reg),
		.retire_data (retire_data),
		.store       (store),
		.store_addr  (store_addr),
		.store_data  (store_data)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#10 clock = ~clock;
		end
	end

	function automatic int unsigned rand_below(int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic word_t base_instr(logic [4:0] rt, logic [4:0] ra, logic [4:0] rb,
			logic [4:0] sub);
		return {1'b0, TY_BASE, rt, ra, rb, 5'd0, sub};
	endfunction

	function automatic word_t imm_instr(logic [5:0] op, logic [4:0] rt, logic [4:0] ra,
			logic [14:0] imm);
		return {1'b0, op, rt, ra, imm};
	endfunction

	function automatic word_t movi_instr(logic [4:0] rt, logic [19:0] imm);
		return {1'b0, MOVI, rt, imm};
	endfunction

	function automatic word_t ls_instr(logic [4:0] rt, logic [4:0] ra, logic [4:0] rb,
			logic [1:0] sv, logic [7:0] sub);
		return {1'b0, TY_LS, rt, ra, rb, sv, sub};
	endfunction

	// unused words decode as an unknown opcode tagged with their address
	function automatic word_t filler_word(int addr);
		return {1'b0, UNKNOWN_OPCODE, 25'(addr)};
	endfunction

	task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
		mismatch_errors++;
		$display("MISMATCH at %0t ns: %s expected 0x%08h actual 0x%08h",
			$time, name, expected, actual);
	endtask

	task automatic model_step(input word_t w);
		logic [5:0] op;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [1:0] sv;
		word_t      a;
		word_t      b;
		word_t      res;
		word_t      addr;
		bit         wr;
		bit         st;
		op = w[30:25];
		rt = w[24:20];
		ra = w[19:15];
		rb = w[14:10];
		sv = w[9:8];
		a = model_regs[ra];
		b = model_regs[rb];
		res = '0;
		addr = '0;
		wr = 1'b1;
		st = 1'b0;
		case (op)
			TY_BASE: begin
				case (w[4:0])
					ADD:     res = a + b;
					SUB:     res = a - b;
					AND:     res = a & b;
					XOR:     res = a ^ b;
					OR:      res = a | b;
					SLLI:    res = a << rb;
					SRLI:    res = a >> rb;
					ROTRI:   res = (a >> rb) | (a << (32 - int'(rb)));
					default: wr = 1'b0;
				endcase
			end
			MOVI: res = {{12{w[19]}}, w[19:0]};
			ADDI: res = a + {{17{w[14]}}, w[14:0]};
			ORI:  res = a | {17'd0, w[14:0]};
			XORI: res = a ^ {17'd0, w[14:0]};
			LWI: begin
				addr = a + {15'd0, w[14:0], 2'b00};
				res = model_mem[addr[MEM_ADDR_BITS+1:2]];
			end
			SWI: begin
				addr = a + {15'd0, w[14:0], 2'b00};
				wr = 1'b0;
				st = 1'b1;
			end
			TY_LS: begin
				addr = a + (b << sv);
				case (w[7:0])
					LW:      res = model_mem[addr[MEM_ADDR_BITS+1:2]];
					SW: begin
						wr = 1'b0;
						st = 1'b1;
					end
					default: wr = 1'b0;
				endcase
			end
			default: wr = 1'b0;
		endcase
		exp_retire.push_back(wr);
		exp_reg.push_back(rt);
		exp_data.push_back(res);
		exp_store.push_back(st);
		exp_addr.push_back(addr);
		exp_sdata.push_back(model_regs[rt]);
		if (st) begin
			model_mem[addr[MEM_ADDR_BITS+1:2]] = model_regs[rt];
			exp_store_total++;
		end
		if (wr) begin
			model_regs[rt] = res;
			exp_retire_total++;
		end
	endtask

	task automatic emit(input word_t w);
		prog.push_back(w);
		model_step(w);
	endtask

	task automatic emit_kind(input int kind);
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [4:0]  shamt;
		logic [14:0] imm;
		logic [1:0]  sv;
		int          word;
		rt = 5'(2 + rand_below(10));
		ra = 5'(rand_below(12));
		rb = 5'(rand_below(12));
		shamt = 5'(rand_below(32));
		imm = 15'($random(seed));
		sv = 2'(rand_below(4));
		word = int'(rand_below(8));
		case (kind)
			0:  emit(base_instr(rt, ra, rb, ADD));
			1:  emit(base_instr(rt, ra, rb, SUB));
			2:  emit(base_instr(rt, ra, rb, AND));
			3:  emit(base_instr(rt, ra, rb, OR));
			4:  emit(base_instr(rt, ra, rb, XOR));
			5:  emit(base_instr(rt, ra, shamt, SLLI));
			6:  emit(base_instr(rt, ra, shamt, SRLI));
			7:  emit(base_instr(rt, ra, shamt, ROTRI));
			8:  emit(imm_instr(ADDI, rt, ra, imm));
			9:  emit(imm_instr(ORI, rt, ra, imm));
			10: emit(imm_instr(XORI, rt, ra, imm));
			11: emit(movi_instr(rt, 20'($random(seed))));
			12: emit(imm_instr(LWI, rt, 5'd0, 15'(word)));
			13: emit(imm_instr(SWI, ra, 5'd0, 15'(word)));
			14, 15: begin
				// r1 carries the index, scaled back up by sv
				emit(movi_instr(5'd1, 20'((word * 4) >> sv)));
				if (kind == 14) begin
					emit(ls_instr(rt, 5'd0, 5'd1, sv, LW));
				end else begin
					emit(ls_instr(ra, 5'd0, 5'd1, sv, SW));
				end
			end
			16: emit({1'b0, UNKNOWN_OPCODE, 25'($random(seed))});
			17: emit(base_instr(rt, ra, rb, 5'b11111));
			default: emit(ls_instr(rt, 5'd0, rb, sv, 8'hff));
		endcase
	endtask

	task automatic build_program();
		int r;
		int p;
		int k;
		for (r = 0; r < 32; r++) begin
			model_regs[r] = '0;
		end
		// r0 stays zero as the base, r1 is the index register
		emit(movi_instr(5'd0, 20'd0));
		emit(movi_instr(5'd1, 20'd0));
		for (r = 2; r < 12; r++) begin
			emit(movi_instr(5'(r), 20'($random(seed))));
		end
		// fill data words 0 to 7 before any load
		for (r = 0; r < 8; r++) begin
			emit(imm_instr(SWI, 5'(2 + rand_below(10)), 5'd0, 15'(r)));
		end
		for (p = 0; p < 2; p++) begin
			for (k = 0; k < NUM_KINDS; k++) begin
				emit_kind((k + 7 * p) % NUM_KINDS);
			end
		end
	endtask

	always @(posedge clock) begin
		if (reset) begin
			core_active <= 1'b0;
			edge_count <= 0;
		end else begin
			core_active <= 1'b1;
			edge_count <= edge_count + 1;
		end
	end

	// outputs are stable at the falling edge
	always @(negedge clock) begin
		int slot;
		int phase;
		bit want_retire;
		bit want_store;
		want_retire = 1'b0;
		want_store = 1'b0;
		if (!core_active) begin
			assert (!retire && !store) else begin
				other_errors++;
				$display("%0t ns: a retire or store strobe pulsed while the core was in reset",
					$time);
			end
		end else begin
			slot = (edge_count - 1) / 5;
			phase = (edge_count - 1) % 5;
			if (slot < prog_len) begin
				want_store = (phase == 3) && exp_store[slot];
				want_retire = (phase == 4) && exp_retire[slot];
			end
			assert (retire == want_retire) else
				report_mismatch("retire", {31'd0, want_retire}, {31'd0, retire});
			assert (store == want_store) else
				report_mismatch("store", {31'd0, want_store}, {31'd0, store});
			if (want_retire && retire) begin
				assert (retire_reg == exp_reg[slot]) else
					report_mismatch("retire_reg", {27'd0, exp_reg[slot]}, {27'd0, retire_reg});
				assert (retire_data == exp_data[slot]) else
					report_mismatch("retire_data", exp_data[slot], retire_data);
			end
			if (want_store && store) begin
				assert (store_addr == exp_addr[slot]) else
					report_mismatch("store_addr", exp_addr[slot], store_addr);
				assert (store_data == exp_sdata[slot]) else
					report_mismatch("store_data", exp_sdata[slot], store_data);
			end
			if (retire) begin
				retire_seen++;
			end
			if (store) begin
				store_seen++;
			end
		end
	end

	initial begin
		wait (running);
		repeat (prog_len * 5 + 50) @(posedge clock);
		$display("watchdog expired before the program finished");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		int a;
		reset = 1'b1;
		prog_write = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		running = 1'b0;
		mismatch_errors = 0;
		other_errors = 0;
		retire_seen = 0;
		store_seen = 0;
		exp_retire_total = 0;
		exp_store_total = 0;
		seed = 68956;
		build_program();
		prog_len = prog.size();
		for (a = 0; a < (1 << MEM_ADDR_BITS); a++) begin
			@(negedge clock);
			prog_write = 1'b1;
			prog_addr = MEM_ADDR_BITS'(a);
			prog_data = (a < prog_len) ? prog[a] : filler_word(a);
		end
		@(negedge clock);
		prog_write = 1'b0;
		// reset stays up 5 more cycles after the load
		repeat (5) @(negedge clock);
		reset = 1'b0;
		running = 1'b1;
		// two filler slots after the program must stay quiet
		wait (edge_count >= 5 * (prog_len + 2));
		@(posedge clock);
		assert (retire_seen == exp_retire_total) else
			report_mismatch("retire count", exp_retire_total, retire_seen);
		assert (store_seen == exp_store_total) else
			report_mismatch("store count", exp_store_total, store_seen);
		$display("errors: %0d mismatches, %0d other; retires %0d of %0d, stores %0d of %0d",
			mismatch_errors, other_errors, retire_seen, exp_retire_total,
			store_seen, exp_store_total);
		if (mismatch_errors == 0 && other_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  isa_pkg::alu_op_t op,
	input  isa_pkg::word_t   a,
	input  isa_pkg::word_t   b,
	output isa_pkg::word_t   result
);
	import isa_pkg::*;

	logic [4:0]             shamt;
	logic [2*WORD_BITS-1:0] rot_wide;

	assign shamt = b[4:0];

	// low half of the doubled word is the right rotation
	assign rot_wide = {a, a} >> shamt;

	always_comb begin
		case (op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_XOR:  result = a ^ b;
			ALU_SRL:  result = a >> shamt;
			ALU_SLL:  result = a << shamt;
			ALU_ROTR: result = rot_wide[WORD_BITS-1:0];
			default:  result = a + b;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/core_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_controller (
	input  logic                  clock,
	input  logic                  reset,
	input  isa_pkg::word_t        instr,
	output logic                  fetch_enable,
	output logic                  reg_fetch_enable,
	output logic                  execute_enable,
	output logic                  memory_enable,
	output logic                  write_back_enable,
	output isa_pkg::alu_op_t      alu_op,
	output isa_pkg::operand_sel_t operand_sel,
	output isa_pkg::extend_sel_t  extend_sel,
	output isa_pkg::wb_sel_t      wb_sel,
	output logic                  reg_write,
	output logic                  mem_read,
	output logic                  mem_write
);
	import isa_pkg::*;

	cpu_state_t  state;
	cpu_state_t  state_next;
	opcode_t     opcode;
	base_subop_t base_subop;
	ls_subop_t   ls_subop;

	assign opcode = field_opcode(instr);
	assign base_subop = field_base_subop(instr);
	assign ls_subop = field_ls_subop(instr);

	always_comb begin
		case (state)
			FETCH:     state_next = REG_FETCH;
			REG_FETCH: state_next = EXECUTE;
			EXECUTE:   state_next = MEMORY;
			MEMORY:    state_next = WRITE_BACK;
			default:   state_next = FETCH;
		endcase
	end

	// strobes are registered and trail the state by one cycle
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= FETCH;
			fetch_enable <= 1'b0;
			reg_fetch_enable <= 1'b0;
			execute_enable <= 1'b0;
			memory_enable <= 1'b0;
			write_back_enable <= 1'b0;
		end else begin
			state <= state_next;
			fetch_enable <= (state == FETCH);
			reg_fetch_enable <= (state == REG_FETCH);
			execute_enable <= (state == EXECUTE);
			memory_enable <= (state == MEMORY);
			write_back_enable <= (state == WRITE_BACK);
		end
	end

	// unknown encodings fall through with every write control low
	always_comb begin
		alu_op = ALU_ADD;
		operand_sel = OPND_REG;
		extend_sel = EXT_IMM5_ZERO;
		wb_sel = WB_ALU;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		case (opcode)
			TY_BASE: begin
				reg_write = 1'b1;
				case (base_subop)
					ADD:     alu_op = ALU_ADD;
					SUB:     alu_op = ALU_SUB;
					AND:     alu_op = ALU_AND;
					XOR:     alu_op = ALU_XOR;
					OR:      alu_op = ALU_OR;
					SLLI: begin
						alu_op = ALU_SLL;
						operand_sel = OPND_IMM;
					end
					SRLI: begin
						alu_op = ALU_SRL;
						operand_sel = OPND_IMM;
					end
					ROTRI: begin
						alu_op = ALU_ROTR;
						operand_sel = OPND_IMM;
					end
					default: reg_write = 1'b0;
				endcase
			end
			MOVI: begin
				extend_sel = EXT_IMM20_SIGN;
				wb_sel = WB_IMM;
				reg_write = 1'b1;
			end
			ADDI: begin
				operand_sel = OPND_IMM;
				extend_sel = EXT_IMM15_SIGN;
				reg_write = 1'b1;
			end
			XORI: begin
				alu_op = ALU_XOR;
				operand_sel = OPND_IMM;
				extend_sel = EXT_IMM15_ZERO;
				reg_write = 1'b1;
			end
			ORI: begin
				alu_op = ALU_OR;
				operand_sel = OPND_IMM;
				extend_sel = EXT_IMM15_ZERO;
				reg_write = 1'b1;
			end
			LWI: begin
				operand_sel = OPND_IMM_OFS;
				extend_sel = EXT_IMM15_ZERO;
				wb_sel = WB_MEM;
				mem_read = 1'b1;
				reg_write = 1'b1;
			end
			SWI: begin
				operand_sel = OPND_IMM_OFS;
				extend_sel = EXT_IMM15_ZERO;
				mem_write = 1'b1;
			end
			TY_LS: begin
				operand_sel = OPND_REG_SV;
				case (ls_subop)
					LW: begin
						wb_sel = WB_MEM;
						mem_read = 1'b1;
						reg_write = 1'b1;
					end
					SW:      mem_write = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/core_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_datapath #(
	parameter int MEM_ADDR_BITS = 8
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     fetch_enable,
	input  logic                     reg_fetch_enable,
	input  logic                     execute_enable,
	input  logic                     memory_enable,
	input  logic                     write_back_enable,
	input  isa_pkg::alu_op_t         alu_op,
	input  isa_pkg::operand_sel_t    operand_sel,
	input  isa_pkg::extend_sel_t     extend_sel,
	input  isa_pkg::wb_sel_t         wb_sel,
	input  logic                     reg_write,
	input  logic                     mem_read,
	input  logic                     mem_write,
	input  isa_pkg::word_t           imem_data,
	input  isa_pkg::word_t           dmem_read_data,
	output isa_pkg::word_t           instr,
	output logic [MEM_ADDR_BITS-1:0] imem_addr,
	output logic                     imem_read,
	output logic [MEM_ADDR_BITS-1:0] dmem_addr,
	output logic                     dmem_read,
	output logic                     dmem_write,
	output isa_pkg::word_t           dmem_write_data,
	output logic                     retire,
	output isa_pkg::reg_addr_t       retire_reg,
	output isa_pkg::word_t           retire_data,
	output logic                     store,
	output isa_pkg::word_t           store_addr,
	output isa_pkg::word_t           store_data
);
	import isa_pkg::*;

	word_t     pc;
	word_t     operand_a;
	word_t     operand_b;
	word_t     alu_result;
	word_t     store_value;
	word_t     ext_imm;
	word_t     alu_b;
	word_t     alu_out;
	word_t     wb_data;
	word_t     read_data_a;
	word_t     read_data_b;
	reg_addr_t read_addr_b;
	logic      rf_write;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
			instr <= '0;
		end else begin
			if (fetch_enable) pc <= pc + 32'd4;
			if (reg_fetch_enable) instr <= imem_data;
		end
	end

	// port b reads rb from the fetched word, then rt for store data
	assign read_addr_b = reg_fetch_enable ? field_rb(imem_data) : field_rt(instr);

	always_ff @(posedge clock) begin
		if (reg_fetch_enable) begin
			operand_a <= read_data_a;
			operand_b <= read_data_b;
		end
		if (execute_enable) begin
			alu_result <= alu_out;
			store_value <= read_data_b;
		end
	end

	always_comb begin
		case (extend_sel)
			EXT_IMM5_ZERO:  ext_imm = {27'd0, field_imm5(instr)};
			EXT_IMM15_SIGN: ext_imm = {{17{instr[14]}}, field_imm15(instr)};
			EXT_IMM15_ZERO: ext_imm = {17'd0, field_imm15(instr)};
			default:        ext_imm = {{12{instr[19]}}, field_imm20(instr)};
		endcase
		case (operand_sel)
			OPND_REG:     alu_b = operand_b;
			OPND_IMM:     alu_b = ext_imm;
			OPND_IMM_OFS: alu_b = ext_imm << 2;
			default:      alu_b = operand_b << field_sv(instr);
		endcase
		case (wb_sel)
			WB_IMM:  wb_data = ext_imm;
			WB_MEM:  wb_data = dmem_read_data;
			default: wb_data = alu_result;
		endcase
	end

	reg_file reg_file_i (
		.clock       (clock),
		.reset       (reset),
		.read_addr_a (field_ra(imem_data)),
		.read_addr_b (read_addr_b),
		.read_data_a (read_data_a),
		.read_data_b (read_data_b),
		.write       (rf_write),
		.write_addr  (field_rt(instr)),
		.write_data  (wb_data)
	);

	alu alu_i (
		.op     (alu_op),
		.a      (operand_a),
		.b      (alu_b),
		.result (alu_out)
	);

	assign imem_addr = pc[MEM_ADDR_BITS+1:2];
	assign imem_read = fetch_enable;
	assign dmem_addr = alu_result[MEM_ADDR_BITS+1:2];
	assign dmem_read = memory_enable & mem_read;
	assign dmem_write = memory_enable & mem_write;
	assign dmem_write_data = store_value;

	assign rf_write = write_back_enable & reg_write;
	assign retire = rf_write;
	assign retire_reg = field_rt(instr);
	assign retire_data = wb_data;
	assign store = dmem_write;
	assign store_addr = alu_result;
	assign store_data = store_value;

endmodule

`default_nettype wire

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
	parameter int MEM_ADDR_BITS = 8
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     prog_write,
	input  logic [MEM_ADDR_BITS-1:0] prog_addr,
	input  isa_pkg::word_t           prog_data,
	output logic                     retire,
	output isa_pkg::reg_addr_t       retire_reg,
	output isa_pkg::word_t           retire_data,
	output logic                     store,
	output isa_pkg::word_t           store_addr,
	output isa_pkg::word_t           store_data
);
	import isa_pkg::*;

	word_t                    instr;
	logic                     fetch_enable;
	logic                     reg_fetch_enable;
	logic                     execute_enable;
	logic                     memory_enable;
	logic                     write_back_enable;
	alu_op_t                  alu_op;
	operand_sel_t             operand_sel;
	extend_sel_t              extend_sel;
	wb_sel_t                  wb_sel;
	logic                     reg_write;
	logic                     mem_read;
	logic                     mem_write;
	word_t                    imem_data;
	logic [MEM_ADDR_BITS-1:0] imem_addr;
	logic                     imem_read;
	word_t                    dmem_read_data;
	logic [MEM_ADDR_BITS-1:0] dmem_addr;
	logic                     dmem_read;
	logic                     dmem_write;
	word_t                    dmem_write_data;

	core_controller core_controller_i (.*);

	core_datapath #(
		.MEM_ADDR_BITS (MEM_ADDR_BITS)
	) core_datapath_i (.*);

	// program port loads instructions while the core is held in reset
	word_memory #(
		.MEM_ADDR_BITS (MEM_ADDR_BITS)
	) imem_i (
		.clock      (clock),
		.read       (imem_read),
		.read_addr  (imem_addr),
		.read_data  (imem_data),
		.write      (prog_write),
		.write_addr (prog_addr),
		.write_data (prog_data)
	);

	word_memory #(
		.MEM_ADDR_BITS (MEM_ADDR_BITS)
	) dmem_i (
		.clock      (clock),
		.read       (dmem_read),
		.read_addr  (dmem_addr),
		.read_data  (dmem_read_data),
		.write      (dmem_write),
		.write_addr (dmem_addr),
		.write_data (dmem_write_data)
	);

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic               clock,
	input  logic               reset,
	input  isa_pkg::reg_addr_t read_addr_a,
	input  isa_pkg::reg_addr_t read_addr_b,
	output isa_pkg::word_t     read_data_a,
	output isa_pkg::word_t     read_data_b,
	input  logic               write,
	input  isa_pkg::reg_addr_t write_addr,
	input  isa_pkg::word_t     write_data
);
	import isa_pkg::*;

	word_t regs [0:(1 << REG_ADDR_BITS)-1];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < (1 << REG_ADDR_BITS); i++) begin
				regs[i] <= '0;
			end
		end else if (write) begin
			regs[write_addr] <= write_data;
		end
	end

	assign read_data_a = regs[read_addr_a];
	assign read_data_b = regs[read_addr_b];

endmodule

`default_nettype wire

// ==== hw/word_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_memory #(
	parameter int MEM_ADDR_BITS = 8
) (
	input  logic                     clock,
	input  logic                     read,
	input  logic [MEM_ADDR_BITS-1:0] read_addr,
	output isa_pkg::word_t           read_data,
	input  logic                     write,
	input  logic [MEM_ADDR_BITS-1:0] write_addr,
	input  isa_pkg::word_t           write_data
);
	import isa_pkg::*;

	word_t mem [0:(1 << MEM_ADDR_BITS)-1];

	// read data holds until the next read
	always_ff @(posedge clock) begin
		if (write) begin
			mem[write_addr] <= write_data;
		end
		if (read) begin
			read_data <= mem[read_addr];
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run cpu_tb with Verilator, then check the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module cpu_tb -f sources.f \
	--Mdir obj_dir -o cpu_tb_sim; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/cpu_tb_sim > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error status"
	exit 1
fi

cat sim.log

if grep -q -F '*** PASSED ***' sim.log; then
	exit 0
fi
exit 1

// ==== sources.f ====
common/isa_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/word_memory.sv
hw/core_controller.sv
hw/core_datapath.sv
hw/cpu_top.sv
dv/cpu_tb.sv
